/* hw/pfc_pkg.sv */
// Shared widths, types and MAC control constants for the PFC receive path; import with pfc_pkg::*.
package pfc_pkg;

    // Receive datapath width, fixed by the frame byte layout.
    localparam int DATA_W = 64;

    // Priority classes carried by a PFC frame.
    localparam int NUM_PRIO = 8;

    // Bit times covered by one pause quantum.
    localparam int QUANTUM_BIT_TIMES = 512;

    // MAC control Ethertype and the PFC opcode (annex 31D).
    localparam logic [15:0] ETH_TYPE_MAC_CTRL = 16'h8808;
    localparam logic [15:0] OPCODE_PFC = 16'h0101;

    // One receive word.
    typedef logic [DATA_W-1:0] word_t;

    // Ethernet address.
    typedef logic [47:0] mac_addr_t;

    // Pause time in quanta, as carried in the frame.
    typedef logic [15:0] quanta_t;

    // One bit per priority class.
    typedef logic [NUM_PRIO-1:0] prio_mask_t;

    // Remaining pause time in bit times, wide enough for 0xFFFF quanta.
    typedef logic [24:0] bit_time_t;

    // Parser position within a frame.
    typedef enum logic [2:0] {
        PS_WORD0,
        PS_WORD1,
        PS_WORD2,
        PS_WORD3,
        PS_WORD4,
        PS_WAIT_LAST,
        PS_DROP
    } parse_state_t;

endpackage

/* hw/pfc_frame_parser.sv */
// Decodes PFC MAC control frames from the receive word stream into one event per accepted frame.
`timescale 1ns/1ns

module pfc_frame_parser import pfc_pkg::*; #(
    parameter mac_addr_t PFC_DST_ADDR = 48'h01_80_C2_00_00_01
) (
    input  logic       rx_clk,
    input  logic       rx_rst,

    // Receive word stream, one word per rx_valid strobe.
    input  word_t      rx_data,
    input  logic       rx_valid,
    input  logic       rx_last,
    input  logic       rx_error,

    // Decoded PFC event.
    output logic       pfc_valid,
    output prio_mask_t pfc_cev,
    output quanta_t    pfc_quanta [NUM_PRIO]
);

    // Field positions inside the words, byte 0 being the top byte of word 0.
    localparam int DST_MSB = DATA_W - 1;
    localparam int TYPE_LSB = 16;
    localparam int OPCODE_LSB = 0;
    localparam int CEV_LSB = 48;

    parse_state_t state;

    logic dst_match;
    logic hdr_match;

    assign dst_match = (rx_data[DST_MSB -: $bits(mac_addr_t)] == PFC_DST_ADDR);
    assign hdr_match = (rx_data[TYPE_LSB +: 16] == ETH_TYPE_MAC_CTRL) &&
                       (rx_data[OPCODE_LSB +: 16] == OPCODE_PFC);

    // Frame walk, one state per strobed word.
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            state <= PS_WORD0;
            pfc_valid <= 1'b0;
        end else begin
            pfc_valid <= 1'b0;
            if (rx_valid) begin
                case (state)
                    PS_WORD0: begin
                        if (rx_last) begin
                            state <= PS_WORD0;
                        end else if (dst_match) begin
                            state <= PS_WORD1;
                        end else begin
                            state <= PS_DROP;
                        end
                    end
                    PS_WORD1: begin
                        if (rx_last) begin
                            state <= PS_WORD0;
                        end else if (hdr_match) begin
                            state <= PS_WORD2;
                        end else begin
                            state <= PS_DROP;
                        end
                    end
                    PS_WORD2: begin
                        state <= rx_last ? PS_WORD0 : PS_WORD3;
                    end
                    PS_WORD3: begin
                        state <= rx_last ? PS_WORD0 : PS_WORD4;
                    end
                    PS_WORD4, PS_WAIT_LAST: begin
                        // Quanta 7 is in, so the frame is complete from here on.
                        if (rx_last) begin
                            pfc_valid <= !rx_error;
                            state <= PS_WORD0;
                        end else begin
                            state <= PS_WAIT_LAST;
                        end
                    end
                    PS_DROP: begin
                        if (rx_last) begin
                            state <= PS_WORD0;
                        end
                    end
                    default: begin
                        state <= PS_WORD0;
                    end
                endcase
            end
        end
    end

    // Capture of class enables and quanta as the words go by.
    always_ff @(posedge rx_clk) begin
        if (rx_valid) begin
            case (state)
                PS_WORD2: begin
                    pfc_cev <= rx_data[CEV_LSB +: NUM_PRIO];
                    for (int j = 0; j < 3; j++) begin
                        pfc_quanta[j] <= rx_data[47 - 16*j -: 16];
                    end
                end
                PS_WORD3: begin
                    for (int j = 0; j < 4; j++) begin
                        pfc_quanta[3 + j] <= rx_data[DATA_W - 1 - 16*j -: 16];
                    end
                end
                PS_WORD4: begin
                    pfc_quanta[7] <= rx_data[DATA_W - 1 -: 16];
                end
                default: begin
                    // Nothing to capture.
                end
            endcase
        end
    end

endmodule

/* hw/pfc_pause_timer.sv */
// Pause timer for a single priority; loads from PFC quanta and counts down one word of bit times.
`timescale 1ns/1ns

module pfc_pause_timer import pfc_pkg::*; (
    input  logic    rx_clk,
    input  logic    rx_rst,

    // Event from the frame parser.
    input  logic    load,
    input  logic    class_en,
    input  logic    prio_en,
    input  quanta_t quanta,

    // Pause level and transition strobes.
    output logic    paused,
    output logic    xon,
    output logic    xoff
);

    localparam bit_time_t STEP = bit_time_t'(DATA_W);

    bit_time_t remaining;
    logic      do_load;

    // Only enabled priorities named in the frame take the new value.
    assign do_load = load && class_en && prio_en;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            remaining <= '0;
            xon <= 1'b0;
            xoff <= 1'b0;
        end else begin
            xon <= 1'b0;
            xoff <= 1'b0;
            if (do_load) begin
                // A new frame overrides whatever pause is still running.
                remaining <= bit_time_t'(quanta) * bit_time_t'(QUANTUM_BIT_TIMES);
                xoff <= (quanta != '0);
                xon <= (quanta == '0);
            end else if (remaining > STEP) begin
                remaining <= remaining - STEP;
            end else begin
                remaining <= '0;
            end
        end
    end

    // Paused until the count has drained.
    assign paused = (remaining != '0);

endmodule

/* hw/pfc_status.sv */
// Output stage of the PFC receive path, instantiated by the top level to register requests and counts.
`timescale 1ns/1ns

module pfc_status import pfc_pkg::*; #(
    parameter int COUNT_W = 16
) (
    input  logic               rx_clk,
    input  logic               rx_rst,

    // Accepted frame strobe from the parser.
    input  logic               frame_valid,

    // Per-priority state from the timers.
    input  prio_mask_t         paused,
    input  prio_mask_t         xon,
    input  prio_mask_t         xoff,

    // Requests and statistics.
    output prio_mask_t         rx_pfc_req,
    output logic               stat_rx_pfc_pkt,
    output prio_mask_t         stat_rx_pfc_xon,
    output prio_mask_t         stat_rx_pfc_xoff,
    output logic [COUNT_W-1:0] stat_rx_pfc_frames
);

    // The frame strobe runs one cycle ahead of the timer outputs.
    logic frame_valid_d;

    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            frame_valid_d <= 1'b0;
            rx_pfc_req <= '0;
            stat_rx_pfc_pkt <= 1'b0;
            stat_rx_pfc_xon <= '0;
            stat_rx_pfc_xoff <= '0;
        end else begin
            frame_valid_d <= frame_valid;
            rx_pfc_req <= paused;
            stat_rx_pfc_pkt <= frame_valid_d;
            stat_rx_pfc_xon <= xon;
            stat_rx_pfc_xoff <= xoff;
        end
    end

    // Accepted frame count, held at all ones once full.
    always_ff @(posedge rx_clk or posedge rx_rst) begin
        if (rx_rst) begin
            stat_rx_pfc_frames <= '0;
        end else if (frame_valid_d && (stat_rx_pfc_frames != '1)) begin
            stat_rx_pfc_frames <= stat_rx_pfc_frames + 1'b1;
        end
    end

endmodule

/* hw/pfc_rx_ctrl.sv */
// Receive PFC top level to instantiate in the MAC, wiring the parser, pause timers and status stage.
`timescale 1ns/1ns

module pfc_rx_ctrl import pfc_pkg::*; #(
    parameter mac_addr_t PFC_DST_ADDR = 48'h01_80_C2_00_00_01,
    parameter int        COUNT_W = 16
) (
    input  logic               rx_clk,
    input  logic               rx_rst,

    // Receive word stream.
    input  word_t              rx_data,
    input  logic               rx_valid,
    input  logic               rx_last,
    input  logic               rx_error,

    // Priorities that honour received pause.
    input  prio_mask_t         rx_pfc_en,

    // Pause requests and statistics.
    output prio_mask_t         rx_pfc_req,
    output logic               stat_rx_pfc_pkt,
    output prio_mask_t         stat_rx_pfc_xon,
    output prio_mask_t         stat_rx_pfc_xoff,
    output logic [COUNT_W-1:0] stat_rx_pfc_frames
);

    logic       pfc_valid;
    prio_mask_t pfc_cev;
    quanta_t    pfc_quanta [NUM_PRIO];

    prio_mask_t paused;
    prio_mask_t xon;
    prio_mask_t xoff;

    pfc_frame_parser #(
        .PFC_DST_ADDR(PFC_DST_ADDR)
    ) u_parser (
        .rx_clk(rx_clk),
        .rx_rst(rx_rst),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .rx_last(rx_last),
        .rx_error(rx_error),
        .pfc_valid(pfc_valid),
        .pfc_cev(pfc_cev),
        .pfc_quanta(pfc_quanta)
    );

    // One timer per priority, all fed by the same event strobe.
    for (genvar i = 0; i < NUM_PRIO; i++) begin : g_timer
        pfc_pause_timer u_timer (
            .rx_clk(rx_clk),
            .rx_rst(rx_rst),
            .load(pfc_valid),
            .class_en(pfc_cev[i]),
            .prio_en(rx_pfc_en[i]),
            .quanta(pfc_quanta[i]),
            .paused(paused[i]),
            .xon(xon[i]),
            .xoff(xoff[i])
        );
    end

    pfc_status #(
        .COUNT_W(COUNT_W)
    ) u_status (
        .rx_clk(rx_clk),
        .rx_rst(rx_rst),
        .frame_valid(pfc_valid),
        .paused(paused),
        .xon(xon),
        .xoff(xoff),
        .rx_pfc_req(rx_pfc_req),
        .stat_rx_pfc_pkt(stat_rx_pfc_pkt),
        .stat_rx_pfc_xon(stat_rx_pfc_xon),
        .stat_rx_pfc_xoff(stat_rx_pfc_xoff),
        .stat_rx_pfc_frames(stat_rx_pfc_frames)
    );

endmodule

/* testbench/pfc_rx_ctrl_tb.sv */
// Random-frame testbench for the PFC receive top level; compile with verilog.f and run as the top.
`timescale 1ns/1ns

module pfc_rx_ctrl_tb import pfc_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 5;
    // Narrow counter so the random run reaches saturation.
    localparam int COUNT_W = 6;
    localparam mac_addr_t DST_ADDR = 48'h01_80_C2_00_00_01;
    localparam int SEED = 32'h37ed_9df4;
    localparam int NUM_RANDOM = 300;
    localparam int MAX_WORDS = 9;
    localparam int MAX_GAP = 300;
    localparam int MAX_QUANTA = 1023;
    localparam int DIRECTED_CYCLES = 5000;
    localparam int CYC_PER_QUANTUM = QUANTUM_BIT_TIMES / DATA_W;
    localparam longint WATCHDOG_CYCLES = 2 * (DIRECTED_CYCLES +
        NUM_RANDOM * (MAX_WORDS + MAX_GAP) + MAX_QUANTA * CYC_PER_QUANTUM);

    // Frame kinds.
    localparam int KIND_VALID = 0;
    localparam int KIND_BAD_DST = 1;
    localparam int KIND_BAD_HDR = 2;
    localparam int KIND_SHORT = 3;
    localparam int KIND_ERROR = 4;

    typedef logic [COUNT_W-1:0] count_t;

    logic       rx_clk;
    logic       rx_rst;
    word_t      rx_data;
    logic       rx_valid;
    logic       rx_last;
    logic       rx_error;
    prio_mask_t rx_pfc_en;
    prio_mask_t rx_pfc_req;
    logic       stat_rx_pfc_pkt;
    prio_mask_t stat_rx_pfc_xon;
    prio_mask_t stat_rx_pfc_xoff;
    count_t     stat_rx_pfc_frames;

    // Frame under construction.
    word_t      frame_words [MAX_WORDS];
    int         frame_len;
    logic       frame_err;
    prio_mask_t frame_cev;
    quanta_t    frame_q [NUM_PRIO];

    // Reference model state for events in flight and remaining request cycles.
    int         req_left [NUM_PRIO];
    logic       end_accept;
    prio_mask_t end_cev;
    quanta_t    end_q [NUM_PRIO];
    logic       ev_e1;
    prio_mask_t ev_e1_cev;
    quanta_t    ev_e1_q [NUM_PRIO];
    logic       ev_e2;
    prio_mask_t ev_e2_mask;
    quanta_t    ev_e2_q [NUM_PRIO];
    count_t     exp_frames;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int test_start_errors;

    pfc_rx_ctrl #(
        .PFC_DST_ADDR(DST_ADDR),
        .COUNT_W(COUNT_W)
    ) i_dut (
        .rx_clk(rx_clk),
        .rx_rst(rx_rst),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .rx_last(rx_last),
        .rx_error(rx_error),
        .rx_pfc_en(rx_pfc_en),
        .rx_pfc_req(rx_pfc_req),
        .stat_rx_pfc_pkt(stat_rx_pfc_pkt),
        .stat_rx_pfc_xon(stat_rx_pfc_xon),
        .stat_rx_pfc_xoff(stat_rx_pfc_xoff),
        .stat_rx_pfc_frames(stat_rx_pfc_frames)
    );

    initial rx_clk = 1'b0;
    always #(CLK_PERIOD / 2) rx_clk = ~rx_clk;

    task automatic check_mask(input string name, input prio_mask_t got, input prio_mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // One clock cycle; model and checks run at the falling edge.
    task automatic tick();
        prio_mask_t exp_req;
        prio_mask_t exp_xon;
        prio_mask_t exp_xoff;
        logic       exp_pkt;
        @(posedge rx_clk);
        @(negedge rx_clk);
        exp_xon = '0;
        exp_xoff = '0;
        exp_pkt = ev_e2;
        for (int i = 0; i < NUM_PRIO; i++) begin
            if (req_left[i] != 0) begin
                req_left[i]--;
            end
        end
        // Outputs reflect the frame two edges after its last word.
        if (ev_e2) begin
            for (int i = 0; i < NUM_PRIO; i++) begin
                if (ev_e2_mask[i]) begin
                    req_left[i] = int'(ev_e2_q[i]) * CYC_PER_QUANTUM;
                    exp_xon[i] = (ev_e2_q[i] == '0);
                    exp_xoff[i] = (ev_e2_q[i] != '0);
                end
            end
            if (exp_frames != '1) begin
                exp_frames++;
            end
        end
        // The enable mask counts at the edge after the last word.
        ev_e2 = ev_e1;
        ev_e2_mask = ev_e1_cev & rx_pfc_en;
        ev_e1 = end_accept;
        ev_e1_cev = end_cev;
        for (int i = 0; i < NUM_PRIO; i++) begin
            ev_e2_q[i] = ev_e1_q[i];
            ev_e1_q[i] = end_q[i];
            exp_req[i] = (req_left[i] != 0);
        end
        end_accept = 1'b0;
        check_mask("rx_pfc_req", rx_pfc_req, exp_req);
        check_bit("stat_rx_pfc_pkt", stat_rx_pfc_pkt, exp_pkt);
        check_mask("stat_rx_pfc_xon", stat_rx_pfc_xon, exp_xon);
        check_mask("stat_rx_pfc_xoff", stat_rx_pfc_xoff, exp_xoff);
        check_count("stat_rx_pfc_frames", stat_rx_pfc_frames, exp_frames);
    endtask

    task automatic idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            tick();
        end
    endtask

    function automatic logic model_busy();
        logic busy;
        busy = ev_e1 || ev_e2;
        for (int i = 0; i < NUM_PRIO; i++) begin
            busy = busy || (req_left[i] != 0);
        end
        return busy;
    endfunction

    // Wait for all pauses to run out, then a few quiet cycles.
    task automatic drain();
        while (model_busy()) begin
            tick();
        end
        idle(3);
    endtask

    function automatic quanta_t random_quanta();
        case ($urandom % 4)
            0: return '0;
            1: return quanta_t'(1 + $urandom % 3);
            2: return quanta_t'($urandom % 64);
            default: return quanta_t'($urandom % (MAX_QUANTA + 1));
        endcase
    endfunction

    // Acceptance rule applied to the words as sent.
    function automatic logic frame_accepted();
        return (frame_len >= 5) && !frame_err &&
               (frame_words[0][63:16] == DST_ADDR) &&
               (frame_words[1][31:16] == ETH_TYPE_MAC_CTRL) &&
               (frame_words[1][15:0] == OPCODE_PFC);
    endfunction

    // Lays out a frame from frame_cev and frame_q, then spoils it by kind.
    task automatic build_frame(input int kind);
        int b;
        frame_words[0] = {DST_ADDR, 16'($urandom)};
        frame_words[1] = {$urandom, ETH_TYPE_MAC_CTRL, OPCODE_PFC};
        frame_words[2] = {8'h00, frame_cev, frame_q[0], frame_q[1], frame_q[2]};
        frame_words[3] = {frame_q[3], frame_q[4], frame_q[5], frame_q[6]};
        frame_words[4] = {frame_q[7], 48'({$urandom, $urandom})};
        for (int w = 5; w < MAX_WORDS; w++) begin
            frame_words[w] = {$urandom, $urandom};
        end
        frame_len = 5 + int'($urandom % (MAX_WORDS - 4));
        frame_err = 1'b0;
        case (kind)
            KIND_BAD_DST: begin
                b = 16 + int'($urandom % 48);
                frame_words[0][b] = ~frame_words[0][b];
            end
            KIND_BAD_HDR: begin
                b = int'($urandom % 32);
                frame_words[1][b] = ~frame_words[1][b];
            end
            KIND_SHORT: frame_len = 1 + int'($urandom % 4);
            KIND_ERROR: frame_err = 1'b1;
            default: ;
        endcase
    endtask

    task automatic send_frame();
        for (int w = 0; w < frame_len; w++) begin
            rx_valid = 1'b1;
            rx_data = frame_words[w];
            rx_last = (w == frame_len - 1);
            rx_error = rx_last && frame_err;
            if (rx_last) begin
                end_accept = frame_accepted();
                end_cev = frame_cev;
                for (int i = 0; i < NUM_PRIO; i++) begin
                    end_q[i] = frame_q[i];
                end
            end
            tick();
        end
        rx_valid = 1'b0;
        rx_last = 1'b0;
        rx_error = 1'b0;
        rx_data = {$urandom, $urandom};
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail (%0d errors)", name, errors - test_start_errors);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int kind;
        void'($urandom(SEED));
        rx_rst = 1'b1;
        rx_data = '0;
        rx_valid = 1'b0;
        rx_last = 1'b0;
        rx_error = 1'b0;
        rx_pfc_en = '1;
        end_accept = 1'b0;
        ev_e1 = 1'b0;
        ev_e2 = 1'b0;
        exp_frames = '0;
        for (int i = 0; i < NUM_PRIO; i++) begin
            req_left[i] = 0;
        end
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;

        start_test();
        idle(RESET_CYCLES);
        rx_rst = 1'b0;
        idle(4);
        end_test("reset_idle");

        // Zero quanta on priority 0 gives xon, the rest xoff.
        start_test();
        frame_cev = 8'hFF;
        for (int i = 0; i < NUM_PRIO; i++) begin
            frame_q[i] = quanta_t'(i);
        end
        build_frame(KIND_VALID);
        send_frame();
        drain();
        end_test("accept_events");

        // Second frame reloads the low half and clears the high half.
        start_test();
        for (int i = 0; i < NUM_PRIO; i++) begin
            frame_q[i] = quanta_t'(10);
        end
        build_frame(KIND_VALID);
        send_frame();
        idle(20);
        for (int i = 0; i < NUM_PRIO; i++) begin
            frame_q[i] = (i < 4) ? quanta_t'(3) : quanta_t'(0);
        end
        build_frame(KIND_VALID);
        send_frame();
        drain();
        end_test("reload_clear");

        start_test();
        for (kind = KIND_BAD_DST; kind <= KIND_ERROR; kind++) begin
            for (int n = 0; n < 3; n++) begin
                frame_cev = prio_mask_t'($urandom);
                for (int i = 0; i < NUM_PRIO; i++) begin
                    frame_q[i] = random_quanta();
                end
                build_frame(kind);
                send_frame();
                idle(int'($urandom % 3));
            end
        end
        drain();
        end_test("reject_frames");

        start_test();
        rx_pfc_en = 8'hA5;
        frame_cev = 8'h3C;
        for (int i = 0; i < NUM_PRIO; i++) begin
            frame_q[i] = quanta_t'(5);
        end
        build_frame(KIND_VALID);
        send_frame();
        drain();
        end_test("masked_priorities");

        // Back-to-back and spaced frames of every kind.
        start_test();
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if ($urandom % 2 == 0) begin
                rx_pfc_en = prio_mask_t'($urandom);
            end
            kind = int'($urandom % 8);
            kind = (kind < 4) ? KIND_VALID : kind - 3;
            frame_cev = prio_mask_t'($urandom);
            for (int i = 0; i < NUM_PRIO; i++) begin
                frame_q[i] = random_quanta();
            end
            build_frame(kind);
            send_frame();
            if ($urandom % 8 == 0) begin
                idle(int'($urandom % MAX_GAP));
            end else begin
                idle(int'($urandom % 4));
            end
        end
        drain();
        end_test("random_frames");

        $display("tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verilog.f */
hw/pfc_pkg.sv
hw/pfc_frame_parser.sv
hw/pfc_pause_timer.sv
hw/pfc_status.sv
hw/pfc_rx_ctrl.sv
testbench/pfc_rx_ctrl_tb.sv

/* Bender.yml */
package:
  name: pfc_rx_ctrl

sources:
  # RTL in compile order.
  - files:
      - hw/pfc_pkg.sv
      - hw/pfc_frame_parser.sv
      - hw/pfc_pause_timer.sv
      - hw/pfc_status.sv
      - hw/pfc_rx_ctrl.sv

  # Testbench, top module pfc_rx_ctrl_tb.
  - target: simulation
    files:
      - testbench/pfc_rx_ctrl_tb.sv
